//--- design/fixp_fmt_pkg.sv
// fixed-point formats of the I/Q gain stage
// sample, gain and full-precision product widths with their signed types
`default_nettype none

package fixp_fmt_pkg;

   // baseband sample width
   parameter int C_SMP_SZ  = 16;

   // gain word is Q1.15
   parameter int C_GAIN_SZ = 16;

   // full-precision product of one sample and the gain
   parameter int C_PROD_SZ = C_SMP_SZ + C_GAIN_SZ;

   // fractional bits dropped when going back to sample width
   parameter int C_FRAC_SZ = 15;

   typedef logic signed [C_SMP_SZ-1:0]  sample_t;
   typedef logic signed [C_GAIN_SZ-1:0] gain_t;
   typedef logic signed [C_PROD_SZ-1:0] prod_t;

endpackage : fixp_fmt_pkg

`default_nettype wire

//--- design/clip_stat_pkg.sv
// clip statistics definitions
// counter width, count type and per-cycle increment type
`default_nettype none

package clip_stat_pkg;

   // width of the clip event counter
   parameter int C_CNT_SZ = 8;

   // accumulated clip count, saturates at all ones
   typedef logic [C_CNT_SZ-1:0] clip_cnt_t;

   // clips seen in one cycle, 0 to 2 with both channels
   typedef logic [1:0] clip_inc_t;

endpackage : clip_stat_pkg

`default_nettype wire

//--- design/gain_mult.sv
// gain multiplier
// registered signed sample times gain at full precision, valid delayed with it
`timescale 1ns/10ps
`default_nettype none

module gain_mult
#(
   parameter int C_SMP_SZ  = fixp_fmt_pkg::C_SMP_SZ,
   parameter int C_GAIN_SZ = fixp_fmt_pkg::C_GAIN_SZ
)
(
   input  wire                     CLK,
   input  wire                     RST,

   input  wire fixp_fmt_pkg::sample_t sample,
   input  wire fixp_fmt_pkg::gain_t   gain,
   input  wire                     valid,

   output fixp_fmt_pkg::prod_t     product,
   output logic                    product_valid
);

   // both operands signed, so the product is sign extended to full width
   logic signed [C_SMP_SZ+C_GAIN_SZ-1:0] mult_full;

   assign mult_full = sample * gain;

   // gain is sampled together with the data, so a new gain
   // takes effect on the next sample registered here
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         product       <= '0;
         product_valid <= 1'b0;
      end
      else
      begin
         product       <= mult_full;
         product_valid <= valid;
      end
   end

endmodule : gain_mult

`default_nettype wire

//--- design/finite_prec_rnd.sv
// symmetric rounding and saturation, product width down to sample width
// round half up, clip to +/- largest magnitude, two cycles of latency
`timescale 1ns/10ps
`default_nettype none

module finite_prec_rnd
#(
   parameter int C_IN_SZ   = fixp_fmt_pkg::C_PROD_SZ,
   parameter int C_OUT_SZ  = fixp_fmt_pkg::C_SMP_SZ,
   parameter int C_FRAC_SZ = fixp_fmt_pkg::C_FRAC_SZ
)
(
   input  wire                     CLK,
   input  wire                     RST,

   input  wire fixp_fmt_pkg::prod_t datain,
   input  wire                     dataval,

   output fixp_fmt_pkg::sample_t   dataout,
   output logic                    clip_inc,
   output logic                    dval_out
);

   // integer part left after dropping the fraction, must be >= C_OUT_SZ
   localparam int C_INT_SZ = C_IN_SZ - C_FRAC_SZ;

   // half an output LSB
   localparam logic signed [C_IN_SZ-1:0] C_HALF_LSB = 1 << (C_FRAC_SZ - 1);

   // symmetric limits, -max instead of the most negative code
   localparam logic signed [C_OUT_SZ-1:0] C_POS_SAT = {1'b0, {(C_OUT_SZ-1){1'b1}}};
   localparam logic signed [C_OUT_SZ-1:0] C_NEG_SAT = {1'b1, {(C_OUT_SZ-2){1'b0}}, 1'b1};

   logic signed [C_IN_SZ-1:0]  rnd_sum;
   logic signed [C_INT_SZ-1:0] rnd_int;
   logic                       sign_d1;
   logic                       val_d1;
   logic                       ovr;

   // stage 1 payload
   // sign is taken from the unrounded product
   always_ff @(posedge CLK)
   begin
      rnd_sum <= datain + C_HALF_LSB;
      sign_d1 <= datain[C_IN_SZ-1];
   end

   // arithmetic shift right by the fraction size
   assign rnd_int = rnd_sum[C_IN_SZ-1:C_FRAC_SZ];

   generate
      if (C_INT_SZ > C_OUT_SZ)
      begin : g_wide
         // in range only if the dropped bits all repeat the output sign bit
         assign ovr = !((&rnd_int[C_INT_SZ-1:C_OUT_SZ-1]) ||
                        !(|rnd_int[C_INT_SZ-1:C_OUT_SZ-1]));
      end
      else
      begin : g_equal
         // no spare integer bits, a wrap shows as a sign flip
         // a result of zero is never a clip
         assign ovr = (rnd_int[C_INT_SZ-1] != sign_d1) && (rnd_int != '0);
      end
   endgenerate

   // stage 2 payload
   always_ff @(posedge CLK)
   begin
      if (ovr)
      begin
         dataout <= sign_d1 ? C_NEG_SAT : C_POS_SAT;
      end
      else
      begin
         dataout <= rnd_int[C_OUT_SZ-1:0];
      end
   end

   // valid pipeline and clip pulse
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         val_d1   <= 1'b0;
         dval_out <= 1'b0;
         clip_inc <= 1'b0;
      end
      else
      begin
         val_d1   <= dataval;
         dval_out <= val_d1;
         // only a valid item may count as a clip
         clip_inc <= val_d1 && ovr;
      end
   end

endmodule : finite_prec_rnd

`default_nettype wire

//--- design/clip_counter.sv
// clip event counter
// adds up to two clips per cycle, saturates, sticky overflow and clear
`timescale 1ns/10ps
`default_nettype none

module clip_counter
#(
   parameter int C_CNT_SZ = clip_stat_pkg::C_CNT_SZ
)
(
   input  wire                         CLK,
   input  wire                         RST,

   input  wire clip_stat_pkg::clip_inc_t clip_add,
   input  wire                         clip_clr,

   output clip_stat_pkg::clip_cnt_t    clip_count,
   output logic                        clip_ovf
);

   logic [C_CNT_SZ-1:0] cnt_q;
   // one extra bit to catch the carry out
   logic [C_CNT_SZ:0]   cnt_sum;

   assign cnt_sum = {1'b0, cnt_q} + {{(C_CNT_SZ+1-$bits(clip_add)){1'b0}}, clip_add};

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         cnt_q    <= '0;
         clip_ovf <= 1'b0;
      end
      // clear wins over a coincident increment
      else if (clip_clr)
      begin
         cnt_q    <= '0;
         clip_ovf <= 1'b0;
      end
      else if (cnt_sum[C_CNT_SZ])
      begin
         // increment lost, hold at max
         cnt_q    <= '1;
         clip_ovf <= 1'b1;
      end
      else
      begin
         cnt_q <= cnt_sum[C_CNT_SZ-1:0];
      end
   end

   assign clip_count = cnt_q;

endmodule : clip_counter

`default_nettype wire

//--- design/gain_stage_top.sv
// I/Q gain stage top level
// shared gain multiply, symmetric round and saturate per channel, clip count
`timescale 1ns/10ps
`default_nettype none

module gain_stage_top
#(
   parameter int C_SMP_SZ  = fixp_fmt_pkg::C_SMP_SZ,
   parameter int C_GAIN_SZ = fixp_fmt_pkg::C_GAIN_SZ,
   parameter int C_FRAC_SZ = fixp_fmt_pkg::C_FRAC_SZ,
   parameter int C_CNT_SZ  = clip_stat_pkg::C_CNT_SZ
)
(
   input  wire                           CLK,
   input  wire                           RST,

   input  wire fixp_fmt_pkg::gain_t      gain,

   input  wire fixp_fmt_pkg::sample_t    in_i,
   input  wire fixp_fmt_pkg::sample_t    in_q,
   input  wire                           in_valid,

   output wire fixp_fmt_pkg::sample_t    out_i,
   output wire fixp_fmt_pkg::sample_t    out_q,
   output wire                           out_valid,

   input  wire                           clip_clr,
   output wire clip_stat_pkg::clip_cnt_t clip_count,
   output wire                           clip_ovf
);

   import fixp_fmt_pkg::*;
   import clip_stat_pkg::*;

   prod_t     prod_i;
   prod_t     prod_q;
   logic      pval_i;
   logic      pval_q;
   logic      clip_i;
   logic      clip_q;
   clip_inc_t clip_sum;

   // multiply, 1 cycle
   gain_mult
   #(
      .C_SMP_SZ  (C_SMP_SZ),
      .C_GAIN_SZ (C_GAIN_SZ)
   )
   mult_i
   (
      .CLK           (CLK),
      .RST           (RST),
      .sample        (in_i),
      .gain          (gain),
      .valid         (in_valid),
      .product       (prod_i),
      .product_valid (pval_i)
   );

   gain_mult
   #(
      .C_SMP_SZ  (C_SMP_SZ),
      .C_GAIN_SZ (C_GAIN_SZ)
   )
   mult_q
   (
      .CLK           (CLK),
      .RST           (RST),
      .sample        (in_q),
      .gain          (gain),
      .valid         (in_valid),
      .product       (prod_q),
      .product_valid (pval_q)
   );

   // round and saturate, 2 cycles
   finite_prec_rnd
   #(
      .C_IN_SZ   (C_SMP_SZ + C_GAIN_SZ),
      .C_OUT_SZ  (C_SMP_SZ),
      .C_FRAC_SZ (C_FRAC_SZ)
   )
   rnd_i
   (
      .CLK      (CLK),
      .RST      (RST),
      .datain   (prod_i),
      .dataval  (pval_i),
      .dataout  (out_i),
      .clip_inc (clip_i),
      .dval_out (out_valid)
   );

   // Q runs in lockstep with I, its valid is not needed
   finite_prec_rnd
   #(
      .C_IN_SZ   (C_SMP_SZ + C_GAIN_SZ),
      .C_OUT_SZ  (C_SMP_SZ),
      .C_FRAC_SZ (C_FRAC_SZ)
   )
   rnd_q
   (
      .CLK      (CLK),
      .RST      (RST),
      .datain   (prod_q),
      .dataval  (pval_q),
      .dataout  (out_q),
      .clip_inc (clip_q),
      .dval_out ()
   );

   // clips from both channels in the same cycle
   assign clip_sum = clip_inc_t'(clip_i) + clip_inc_t'(clip_q);

   clip_counter
   #(
      .C_CNT_SZ (C_CNT_SZ)
   )
   clip_counter_inst
   (
      .CLK        (CLK),
      .RST        (RST),
      .clip_add   (clip_sum),
      .clip_clr   (clip_clr),
      .clip_count (clip_count),
      .clip_ovf   (clip_ovf)
   );

endmodule : gain_stage_top

`default_nettype wire

//--- verif/gain_stage_tb.sv
// testbench of the I/Q gain stage
// table-driven stimulus, reference rounding and clip counter models
`timescale 1ns/10ps
`default_nettype none

module gain_stage_tb;

   import fixp_fmt_pkg::*;
   import clip_stat_pkg::*;

   localparam int     CLK_PERIOD = 4;
   localparam int     LATENCY    = 3;
   localparam int     N_RAND     = 48;
   localparam int     N_OVF      = 130;
   localparam int     CNT_MAX    = (1 << C_CNT_SZ) - 1;
   localparam longint SMP_MAX    = (longint'(1) << (C_SMP_SZ - 1)) - 1;
   localparam longint SMP_MIN    = -(longint'(1) << (C_SMP_SZ - 1));

   typedef struct {
      int      test;
      bit      valid;
      bit      clr;
      gain_t   gain;
      sample_t i;
      sample_t q;
      sample_t exp_i;
      sample_t exp_q;
      int      nclip;
   } entry_t;

   typedef struct {
      sample_t i;
      sample_t q;
      int      cyc;
   } pending_t;

   logic      CLK;
   logic      RST;
   gain_t     gain;
   sample_t   in_i;
   sample_t   in_q;
   logic      in_valid;
   sample_t   out_i;
   sample_t   out_q;
   logic      out_valid;
   logic      clip_clr;
   clip_cnt_t clip_count;
   logic      clip_ovf;

   entry_t   tbl[$];
   pending_t pend_q[$];
   int       clip_pipe[$];
   string    test_name [8] = '{"idle after reset", "rounding in range", "positive saturation",
                               "negative extremes", "streaming", "clip counting", "overflow",
                               "random"};
   bit       table_built = 1'b0;
   int       cyc = 0;
   int       mdl_cnt = 0;
   logic     mdl_ovf = 1'b0;
   int       t_checks = 0;
   int       t_errs = 0;
   int       n_checks = 0;
   int       n_errs = 0;
   int       n_tests = 0;

   gain_stage_top gain_stage_top_inst
   (
      .CLK        (CLK),
      .RST        (RST),
      .gain       (gain),
      .in_i       (in_i),
      .in_q       (in_q),
      .in_valid   (in_valid),
      .out_i      (out_i),
      .out_q      (out_q),
      .out_valid  (out_valid),
      .clip_clr   (clip_clr),
      .clip_count (clip_count),
      .clip_ovf   (clip_ovf)
   );

   initial
   begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   // round half up, then symmetric saturation on the sign of the raw product
   function automatic void ref_scale(input sample_t x, input gain_t g,
                                     output sample_t y, output bit clip);
      longint prod;
      longint r;
      prod = longint'(x) * longint'(g);
      r    = (prod + (longint'(1) << (C_FRAC_SZ - 1))) >>> C_FRAC_SZ;
      if (r > SMP_MAX || r < SMP_MIN)
      begin
         clip = 1'b1;
         y    = sample_t'((prod >= 0) ? SMP_MAX : -SMP_MAX);
      end
      else
      begin
         clip = 1'b0;
         y    = sample_t'(r);
      end
   endfunction

   function automatic entry_t make_entry(input int t, input bit v, input bit c, input int g,
                                         input int a, input int b, input int ea,
                                         input int eb, input int n);
      entry_t e;
      e.test  = t;
      e.valid = v;
      e.clr   = c;
      e.gain  = gain_t'(g);
      e.i     = sample_t'(a);
      e.q     = sample_t'(b);
      e.exp_i = sample_t'(ea);
      e.exp_q = sample_t'(eb);
      e.nclip = v ? n : 0;
      return e;
   endfunction

   function automatic void add_entry(input int t, input bit v, input bit c, input int g,
                                     input int a, input int b, input int ea,
                                     input int eb, input int n);
      tbl.push_back(make_entry(t, v, c, g, a, b, ea, eb, n));
   endfunction

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      t_checks++;
      if (got !== exp)
      begin
         $display("[ERROR] %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
         t_errs++;
      end
   endtask

   task automatic check_count(input string name, input clip_cnt_t got, input clip_cnt_t exp);
      t_checks++;
      if (got !== exp)
      begin
         $display("[ERROR] %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
         t_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      t_checks++;
      if (got !== exp)
      begin
         $display("[ERROR] %0t ns: %s got %b, expected %b", $time, name, got, exp);
         t_errs++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("problem at %0t ns: %s", $time, msg);
      t_errs++;
   endtask

   // directed entries carry hand-worked results, random ones use ref_scale
   task automatic build_table();
      int      n;
      bit      v;
      bit      c;
      gain_t   g;
      sample_t a;
      sample_t b;
      sample_t ei;
      sample_t eq;
      bit      ci;
      bit      cq;
      for (n = 0; n < 4; n++)
         add_entry(0, 1'b0, 1'b0, 0, 0, 0, 0, 0, 0);
      add_entry(1, 1'b1, 1'b0, 32767, 1000, -1000, 1000, -1000, 0);
      add_entry(1, 1'b1, 1'b0, 32767, 32767, -32768, 32766, -32767, 0);
      add_entry(1, 1'b1, 1'b0, 32767, 0, 1, 0, 1, 0);
      // exact half LSB products
      add_entry(1, 1'b1, 1'b0, 16384, 3, -3, 2, -1, 0);
      add_entry(1, 1'b1, 1'b0, 16384, 1, -1, 1, 0, 0);
      add_entry(1, 1'b1, 1'b0, 16384, 32767, -32768, 16384, -16384, 0);
      add_entry(1, 1'b1, 1'b0, 1, 16384, -16384, 1, 0, 0);
      add_entry(1, 1'b1, 1'b0, 1, 16383, -16385, 0, -1, 0);
      add_entry(1, 1'b1, 1'b0, 2, 8192, -8193, 1, -1, 0);
      add_entry(2, 1'b1, 1'b0, -32768, -32768, -32768, 32767, 32767, 2);
      add_entry(2, 1'b1, 1'b0, -32768, -32768, 100, 32767, -100, 1);
      add_entry(2, 1'b1, 1'b0, -32768, 5, -32768, -5, 32767, 1);
      add_entry(3, 1'b1, 1'b0, 32767, -32768, 32767, -32767, 32766, 0);
      add_entry(3, 1'b1, 1'b0, -32768, 32767, -32767, -32767, 32767, 0);
      add_entry(3, 1'b1, 1'b0, -32767, -32768, 32767, 32767, -32766, 0);
      add_entry(3, 1'b1, 1'b0, 32767, -32767, -1, -32766, -1, 0);
      // gain changes on every entry
      add_entry(4, 1'b1, 1'b0, 8192, 1000, -6, 250, -1, 0);
      add_entry(4, 1'b1, 1'b0, 16384, -5, 7, -2, 4, 0);
      add_entry(4, 1'b1, 1'b0, -32768, 1234, -4321, -1234, 4321, 0);
      add_entry(4, 1'b1, 1'b0, 32767, -20000, 20000, -19999, 19999, 0);
      add_entry(4, 1'b1, 1'b0, 0, 32767, -32768, 0, 0, 0);
      add_entry(4, 1'b1, 1'b0, 1, 16384, -16384, 1, 0, 0);
      add_entry(4, 1'b1, 1'b0, 24576, 100, -100, 75, -75, 0);
      // the clear lines up with the double clip three entries before it
      add_entry(5, 1'b1, 1'b0, -32768, -32768, -32768, 32767, 32767, 2);
      add_entry(5, 1'b1, 1'b0, 16384, 2, 2, 1, 1, 0);
      add_entry(5, 1'b1, 1'b0, 16384, 2, 2, 1, 1, 0);
      add_entry(5, 1'b1, 1'b1, -32768, -32768, -32768, 32767, 32767, 2);
      add_entry(5, 1'b1, 1'b0, 16384, 2, 2, 1, 1, 0);
      add_entry(5, 1'b1, 1'b0, 16384, 2, 2, 1, 1, 0);
      add_entry(5, 1'b1, 1'b0, 16384, 2, 2, 1, 1, 0);
      add_entry(5, 1'b0, 1'b1, 0, 0, 0, 0, 0, 0);
      for (n = 0; n < N_OVF; n++)
         add_entry(6, 1'b1, 1'b0, -32768, -32768, -32768, 32767, 32767, 2);
      for (n = 0; n < 3; n++)
         add_entry(6, 1'b1, 1'b0, 0, 0, 0, 0, 0, 0);
      add_entry(6, 1'b0, 1'b1, 0, 0, 0, 0, 0, 0);
      add_entry(6, 1'b0, 1'b0, 0, 0, 0, 0, 0, 0);
      for (n = 0; n < N_RAND; n++)
      begin
         v = ($urandom % 8) != 0;
         c = ($urandom % 16) == 0;
         g = gain_t'($urandom);
         a = sample_t'($urandom);
         b = sample_t'($urandom);
         // steer some entries into the clip corner
         if ($urandom % 4 == 0)
         begin
            g = gain_t'(-32768);
            a = sample_t'(-32768);
         end
         ref_scale(a, g, ei, ci);
         ref_scale(b, g, eq, cq);
         add_entry(7, v, c, int'(g), int'(a), int'(b), int'(ei), int'(eq), ci + cq);
      end
   endtask

   // one clock: check what the last rising edge produced, then drive the next entry
   task automatic run_cycle(input entry_t e);
      pending_t p;
      int       inc;
      @(negedge CLK);
      cyc++;
      check_count("clip_count", clip_count, clip_cnt_t'(mdl_cnt));
      check_flag("clip_ovf", clip_ovf, mdl_ovf);
      if (out_valid === 1'b1)
      begin
         if (pend_q.size() == 0)
         begin
            note_failure("out_valid went high with no sample in flight");
         end
         else
         begin
            p = pend_q.pop_front();
            if (cyc - p.cyc != LATENCY)
               note_failure($sformatf("result came %0d cycles after its input, expected %0d",
                                      cyc - p.cyc, LATENCY));
            check_sample("out_i", out_i, p.i);
            check_sample("out_q", out_q, p.q);
         end
      end
      gain     = e.gain;
      in_i     = e.i;
      in_q     = e.q;
      in_valid = e.valid;
      clip_clr = e.clr;
      if (e.valid)
      begin
         p.i   = e.exp_i;
         p.q   = e.exp_q;
         p.cyc = cyc;
         pend_q.push_back(p);
      end
      // counter sees this clear with the clips of the entry three cycles back
      clip_pipe.push_back(e.nclip);
      inc = clip_pipe.pop_front();
      if (e.clr)
      begin
         mdl_cnt = 0;
         mdl_ovf = 1'b0;
      end
      else if (mdl_cnt + inc > CNT_MAX)
      begin
         mdl_cnt = CNT_MAX;
         mdl_ovf = 1'b1;
      end
      else
      begin
         mdl_cnt = mdl_cnt + inc;
      end
   endtask

   // flush the pipeline, then report the test
   task automatic finish_test(input int t);
      entry_t idle;
      int     n;
      idle = make_entry(t, 1'b0, 1'b0, 0, 0, 0, 0, 0, 0);
      n    = 0;
      while (pend_q.size() != 0 && n < 2 * LATENCY + 4)
      begin
         run_cycle(idle);
         n++;
      end
      if (pend_q.size() != 0)
      begin
         note_failure($sformatf("%0d samples never came out", pend_q.size()));
         pend_q.delete();
      end
      repeat (2) run_cycle(idle);
      $display("test %0d, %s: %0d checks, %0d errors", t, test_name[t], t_checks, t_errs);
      n_tests++;
      n_checks += t_checks;
      n_errs   += t_errs;
      t_checks = 0;
      t_errs   = 0;
   endtask

   initial
   begin
      int k;
      int cur;
      RST      = 1'b1;
      gain     = '0;
      in_i     = '0;
      in_q     = '0;
      in_valid = 1'b0;
      clip_clr = 1'b0;
      void'($urandom(32'h74560bdf));
      build_table();
      for (k = 0; k < LATENCY; k++)
         clip_pipe.push_back(0);
      table_built = 1'b1;
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      RST = 1'b0;
      cur = tbl[0].test;
      for (k = 0; k < tbl.size(); k++)
      begin
         if (tbl[k].test != cur)
         begin
            finish_test(cur);
            cur = tbl[k].test;
         end
         run_cycle(tbl[k]);
      end
      finish_test(cur);
      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errs);
      if (n_errs == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // twice the table length plus margin for reset and pipeline flushes
   initial
   begin
      wait (table_built);
      #((tbl.size() + 20) * CLK_PERIOD * 2);
      $display("watchdog expired at %0t ns, the run did not complete in time", $time);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule : gain_stage_tb

`default_nettype wire

//--- build.f
design/fixp_fmt_pkg.sv
design/clip_stat_pkg.sv
design/gain_mult.sv
design/finite_prec_rnd.sv
design/clip_counter.sv
design/gain_stage_top.sv
verif/gain_stage_tb.sv
